// ==== sxp_cfg.svh ====
// SXP core configuration
`ifndef SXP_CFG_SVH
`define SXP_CFG_SVH

`define SXP_DATA_W     32        // data and address width
`define SXP_INST_W     32        // instruction width
`define SXP_RF_AW      4         // register address width
`define SXP_RF_N       16        // number of registers

// instruction fields
`define SXP_F_DEST     31:30     // destination config
`define SXP_F_SRC      29:27     // operand source config
`define SXP_F_OP       26:24     // alu op
`define SXP_F_WB       23:20     // write-back select
`define SXP_F_DADDR    19:16     // destination register
`define SXP_F_RA       15:12     // register a
`define SXP_F_RB       11:8      // register b
`define SXP_F_IMM      15:0      // immediate, zero extended
`define SXP_F_JZ       1         // jump on zero when set
`define SXP_F_CJ       0         // conditional jump

`define SXP_DEST_REG   2'b00
`define SXP_DEST_JUMP  2'b01
`define SXP_DEST_STORE 2'b10     // 2'b11 is a nop

`define SXP_SRC_RR     3'b000    // reg a, reg b
`define SXP_SRC_RI     3'b001    // reg a, immediate
`define SXP_SRC_PR     3'b010    // pc, reg b
`define SXP_SRC_PI     3'b011    // pc, immediate

`define SXP_OP_ADD     3'd0
`define SXP_OP_SUB     3'd1
`define SXP_OP_AND     3'd2
`define SXP_OP_OR      3'd3
`define SXP_OP_XOR     3'd4
`define SXP_OP_SHL     3'd5
`define SXP_OP_SHR     3'd6
`define SXP_OP_PASSB   3'd7

`define SXP_FLAG_Z     0         // flag bit positions
`define SXP_FLAG_N     1
`define SXP_FLAG_V     2
`define SXP_FLAG_C     3

`endif

// ==== sxp_pkg.sv ====
// SXP shared types
`default_nettype none

`include "sxp_cfg.svh"

package sxp_pkg;

  typedef logic [`SXP_DATA_W-1:0] data_t;     // data word or address
  typedef logic [`SXP_INST_W-1:0] inst_t;     // instruction word
  typedef logic [`SXP_RF_AW-1:0]  reg_addr_t; // register index
  typedef logic [3:0]             flags_t;    // c v n z, z in bit 0

  // control that rides along with an instruction down the pipe
  typedef struct packed {
    logic      vld;                           // live instruction
    logic [1:0] dest_cfg;                     // reg, jump, store or nop
    reg_addr_t dest_addr;                     // register to write
    logic [2:0] alu_op;
    logic [3:0] wb_sel;                       // write-back source
    logic      cond_jump;                     // jump depends on yb[0]
    logic      jz;                            // take jump when yb[0] is 0
    data_t     pcn;                           // address after this instruction
  } ctrl_t;

  // scratch-pad store port
  typedef struct packed {
    logic  we;
    data_t addr;
    data_t data;
  } store_t;

endpackage

`default_nettype wire

// ==== sxp_fetch.sv ====
// SXP instruction fetch
`timescale 1ns/1ps
`default_nettype none

module sxp_fetch (
  input  wire                 clk,
  input  wire                 reset_b,
  input  wire                 halt,
  input  wire                 stall,
  input  wire                 set_pc,
  input  wire sxp_pkg::data_t pc_target,
  input  wire sxp_pkg::inst_t mem_inst,
  output sxp_pkg::data_t      mem_pc,
  output sxp_pkg::inst_t      inst,
  output logic                inst_vld,
  output sxp_pkg::data_t      pcn
);
  import sxp_pkg::*;

  data_t pc;                                  // address on the memory bus
  data_t pcn_q;                               // address after the stage 1 word
  inst_t hold_q;                              // stage 1 word kept over a hold
  logic  hold_sel;                            // present hold_q, not the memory
  logic  vld_q;                               // memory answers a live fetch
  logic  hold;

  assign hold     = stall || halt;            // memory keeps answering, pc waits
  assign mem_pc   = pc;
  assign inst_vld = vld_q;
  assign pcn      = pcn_q;
  assign inst     = vld_q ? (hold_sel ? hold_q : mem_inst) : '0;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      pc       <= '0;
      vld_q    <= 1'b0;
      hold_sel <= 1'b0;
    end
    else if (set_pc)                          // jump wins over a stall
    begin
      pc       <= pc_target;
      vld_q    <= 1'b0;                       // word for target is a cycle away
      hold_sel <= 1'b0;
    end
    else if (hold)
      hold_sel <= 1'b1;
    else
    begin
      pc       <= pc + 1'b1;
      vld_q    <= 1'b1;
      hold_sel <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (hold)
      hold_q <= inst;                         // memory moves on to pc next cycle
    else
      pcn_q  <= pc + 1'b1;
  end

endmodule

`default_nettype wire

// ==== sxp_regf.sv ====
// SXP register file
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_regf (
  input  wire                     clk,
  input  wire                     reset_b,
  input  wire                     halt,
  input  wire sxp_pkg::reg_addr_t addra,
  input  wire sxp_pkg::reg_addr_t addrb,
  input  wire                     a_en,
  input  wire                     b_en,
  input  wire                     wec,
  input  wire sxp_pkg::reg_addr_t addrc,
  input  wire sxp_pkg::data_t     dc,
  output sxp_pkg::data_t          qra,
  output sxp_pkg::data_t          qrb
);
  import sxp_pkg::*;

  data_t mem [`SXP_RF_N];                     // register array

  always_ff @(posedge clk)
  begin
    if (wec && !halt)
      mem[addrc] <= dc;                       // seen by reads one cycle later
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      qra <= '0;
      qrb <= '0;
    end
    else if (!halt)
    begin
      if (a_en)
        qra <= mem[addra];                    // port a keeps last value otherwise
      if (b_en)
        qrb <= mem[addrb];
    end
  end

  // write-back must always name a register
  a_wec_addr: assert property (@(posedge clk) disable iff (!reset_b)
    $rose(wec) |-> !$isunknown(addrc));

endmodule

`default_nettype wire

// ==== sxp_scoreboard.sv ====
// SXP register scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_scoreboard (
  input  wire                     clk,
  input  wire                     reset_b,
  input  wire                     halt,
  input  wire                     flush,
  input  wire                     dest_en,
  input  wire sxp_pkg::reg_addr_t dest_addr,
  input  wire sxp_pkg::reg_addr_t addra,
  input  wire sxp_pkg::reg_addr_t addrb,
  input  wire                     a_en,
  input  wire                     b_en,
  input  wire                     wec,
  input  wire sxp_pkg::reg_addr_t addrc,
  output logic                    stall
);

  logic [`SXP_RF_N-1:0] pend;                 // one write in flight per register
  logic                 issue;                // stage 1 write leaves for stage 2

  // raw on either source and waw on the destination
  assign stall = (a_en && pend[addra]) ||
                 (b_en && pend[addrb]) ||
                 (dest_en && pend[dest_addr]);

  assign issue = dest_en && !stall;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      pend <= '0;
    else if (flush)
      pend <= '0;                             // jump drops every younger write
    else if (!halt)
    begin
      if (wec)
        pend[addrc] <= 1'b0;                  // result lands this cycle
      if (issue)
        pend[dest_addr] <= 1'b1;
    end
  end

  // a write-back always belongs to an issued write
  a_wec_pending: assert property (@(posedge clk) disable iff (!reset_b)
    wec |-> pend[addrc]);

endmodule

`default_nettype wire

// ==== sxp_decode.sv ====
// SXP decode and operand stages
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_decode (
  input  wire                 clk,
  input  wire                 reset_b,
  input  wire                 halt,
  input  wire                 stall,
  input  wire                 flush,
  input  wire sxp_pkg::inst_t inst,
  input  wire                 inst_vld,
  input  wire sxp_pkg::data_t pcn,
  input  wire sxp_pkg::data_t qra,
  input  wire sxp_pkg::data_t qrb,
  output sxp_pkg::reg_addr_t  addra,
  output sxp_pkg::reg_addr_t  addrb,
  output logic                a_en,
  output logic                b_en,
  output logic                dest_en,
  output sxp_pkg::data_t      a_3,
  output sxp_pkg::data_t      b_3,
  output sxp_pkg::ctrl_t      ctrl_3
);
  import sxp_pkg::*;

  logic [2:0]  src_raw;                       // source field as fetched
  logic [2:0]  src_1;                         // reserved 1xx codes run as rr
  ctrl_t       ctrl_1;
  ctrl_t       ctrl_2;                        // lines up with registered qra qrb
  logic [2:0]  src_2;
  logic [15:0] imm_2;
  data_t       a_2;
  data_t       b_2;

  assign src_raw = inst[`SXP_F_SRC];
  assign src_1   = src_raw[2] ? `SXP_SRC_RR : src_raw;

  // ri reads its a operand from the destination register
  assign addra   = (src_1 == `SXP_SRC_RI) ? inst[`SXP_F_DADDR] : inst[`SXP_F_RA];
  assign addrb   = inst[`SXP_F_RB];
  assign a_en    = inst_vld && (src_1 == `SXP_SRC_RR || src_1 == `SXP_SRC_RI);
  assign b_en    = inst_vld && (src_1 == `SXP_SRC_RR || src_1 == `SXP_SRC_PR);
  assign dest_en = inst_vld && (inst[`SXP_F_DEST] == `SXP_DEST_REG);

  always_comb
  begin
    ctrl_1.vld       = inst_vld && !stall;     // bubble while the scoreboard holds
    ctrl_1.dest_cfg  = inst[`SXP_F_DEST];
    ctrl_1.dest_addr = inst[`SXP_F_DADDR];
    ctrl_1.alu_op    = inst[`SXP_F_OP];
    ctrl_1.wb_sel    = inst[`SXP_F_WB];
    ctrl_1.cond_jump = inst[`SXP_F_CJ] && b_en; // needs reg b for its test
    ctrl_1.jz        = inst[`SXP_F_JZ];
    ctrl_1.pcn       = pcn;
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      ctrl_2 <= '0;
    else if (flush)
      ctrl_2.vld <= 1'b0;
    else if (!halt)
      ctrl_2 <= ctrl_1;
  end

  always_ff @(posedge clk)
  begin
    if (!halt)
    begin
      src_2 <= src_1;
      imm_2 <= inst[`SXP_F_IMM];
    end
  end

  // a is reg or pc and b is reg or immediate
  assign a_2 = (src_2 == `SXP_SRC_PR || src_2 == `SXP_SRC_PI) ? ctrl_2.pcn : qra;
  assign b_2 = (src_2 == `SXP_SRC_RI || src_2 == `SXP_SRC_PI) ? {16'b0, imm_2} : qrb;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      ctrl_3 <= '0;
    else if (flush)
      ctrl_3.vld <= 1'b0;
    else if (!halt)
      ctrl_3 <= ctrl_2;
  end

  always_ff @(posedge clk)
  begin
    if (!halt)
    begin
      a_3 <= a_2;
      b_3 <= b_2;
    end
  end

  // no live word reaches the alu in the three cycles after a taken jump
  a_flush_kills: assert property (@(posedge clk) disable iff (!reset_b)
    ($past(flush) || $past(flush, 2) || $past(flush, 3)) |-> !ctrl_3.vld);

endmodule

`default_nettype wire

// ==== sxp_alu.sv ====
// SXP arithmetic logic unit
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_alu (
  input  wire [2:0]           op,
  input  wire sxp_pkg::data_t a,
  input  wire sxp_pkg::data_t b,
  output sxp_pkg::data_t      ya,
  output sxp_pkg::data_t      yb,
  output sxp_pkg::flags_t     fa,
  output sxp_pkg::flags_t     fb
);
  import sxp_pkg::*;

  localparam int msb = `SXP_DATA_W - 1;

  data_t sum;
  data_t diff;
  logic  c_add;
  logic  c_sub;                               // borrow out of a - b
  logic  v_add;
  logic  v_sub;

  assign {c_add, sum}  = {1'b0, a} + {1'b0, b};
  assign {c_sub, diff} = {1'b0, a} - {1'b0, b};
  assign v_add = (a[msb] == b[msb]) && (sum[msb] != a[msb]);  // like signs flip
  assign v_sub = (a[msb] != b[msb]) && (diff[msb] != a[msb]); // unlike signs flip

  always_comb
  begin
    case (op)
      `SXP_OP_ADD:   ya = sum;
      `SXP_OP_SUB:   ya = diff;
      `SXP_OP_AND:   ya = a & b;
      `SXP_OP_OR:    ya = a | b;
      `SXP_OP_XOR:   ya = a ^ b;
      `SXP_OP_SHL:   ya = a << b[4:0];
      `SXP_OP_SHR:   ya = a >> b[4:0];       // logical shift
      `SXP_OP_PASSB: ya = b;
    endcase
  end

  assign yb = b;                              // b passes through for stores and tests

  // carry and overflow only mean something for add and subtract
  assign fa[`SXP_FLAG_C] = (op == `SXP_OP_ADD) ? c_add : (op == `SXP_OP_SUB) ? c_sub : 1'b0;
  assign fa[`SXP_FLAG_V] = (op == `SXP_OP_ADD) ? v_add : (op == `SXP_OP_SUB) ? v_sub : 1'b0;
  assign fa[`SXP_FLAG_N] = ya[msb];
  assign fa[`SXP_FLAG_Z] = (ya == '0);

  assign fb[`SXP_FLAG_C] = 1'b0;
  assign fb[`SXP_FLAG_V] = 1'b0;
  assign fb[`SXP_FLAG_N] = yb[msb];
  assign fb[`SXP_FLAG_Z] = (yb == '0);

endmodule

`default_nettype wire

// ==== sxp_writeback.sv ====
// SXP write-back stage
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_writeback (
  input  wire                  clk,
  input  wire                  reset_b,
  input  wire                  halt,
  input  wire                  flush,
  input  wire sxp_pkg::ctrl_t  ctrl_3,
  input  wire sxp_pkg::data_t  ya,
  input  wire sxp_pkg::data_t  yb,
  input  wire sxp_pkg::flags_t fa,
  input  wire sxp_pkg::flags_t fb,
  output logic                 wec,
  output sxp_pkg::reg_addr_t   addrc,
  output sxp_pkg::data_t       dc,
  output logic                 set_pc,
  output sxp_pkg::data_t       pc_target,
  output sxp_pkg::store_t      spw
);
  import sxp_pkg::*;

  ctrl_t  ctrl_4;
  data_t  ya_4;
  data_t  yb_4;                               // store address and jump test bit
  flags_t fa_4;
  flags_t fb_4;
  data_t  wb_data;
  logic   act;                                // stage 4 may act this cycle
  logic   take;                               // jump condition met

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      ctrl_4 <= '0;
    else if (flush)
      ctrl_4.vld <= 1'b0;                     // slot behind the jump is dropped
    else if (!halt)
      ctrl_4 <= ctrl_3;
  end

  always_ff @(posedge clk)
  begin
    if (!halt)
    begin
      ya_4 <= ya;
      yb_4 <= yb;
      fa_4 <= fa;
      fb_4 <= fb;
    end
  end

  // 01xx picks an fa flag and 10xx an fb flag, 0010 0011 and 11xx fall back to ya
  always_comb
  begin
    case (ctrl_4.wb_sel[3:2])
      2'b01:   wb_data = {{(`SXP_DATA_W-1){1'b0}}, fa_4[ctrl_4.wb_sel[1:0]]};
      2'b10:   wb_data = {{(`SXP_DATA_W-1){1'b0}}, fb_4[ctrl_4.wb_sel[1:0]]};
      default: wb_data = (ctrl_4.wb_sel == 4'b0001) ? yb_4 : ya_4;
    endcase
  end

  assign act  = ctrl_4.vld && !halt;          // one pulse per instruction
  assign take = ctrl_4.cond_jump ? (yb_4[0] ^ ctrl_4.jz) : 1'b1;

  assign wec       = act && (ctrl_4.dest_cfg == `SXP_DEST_REG);
  assign addrc     = ctrl_4.dest_addr;
  assign dc        = wb_data;

  // a jump to the next address changes nothing so skip the flush
  assign set_pc    = act && (ctrl_4.dest_cfg == `SXP_DEST_JUMP) && take &&
                     (wb_data != ctrl_4.pcn);
  assign pc_target = wb_data;

  assign spw = '{we:   act && (ctrl_4.dest_cfg == `SXP_DEST_STORE),
                 addr: yb_4,
                 data: wb_data};

endmodule

`default_nettype wire

// ==== sxp_core.sv ====
// SXP pipelined core
`timescale 1ns/1ps
`default_nettype none

`include "sxp_cfg.svh"

module sxp_core (
  input  wire                 clk,
  input  wire                 reset_b,
  input  wire                 halt,
  input  wire sxp_pkg::inst_t mem_inst,
  output sxp_pkg::data_t      mem_pc,
  output sxp_pkg::store_t     spw
);
  import sxp_pkg::*;

  inst_t     inst_1;                          // stage 1 word
  logic      inst_vld_1;
  data_t     pcn_1;
  reg_addr_t addra;
  reg_addr_t addrb;
  logic      a_en;
  logic      b_en;
  logic      dest_en;                         // stage 1 writes a register
  logic      stall_fe;                        // hazard hold on fetch and stage 2 entry
  data_t     qra;
  data_t     qrb;
  data_t     a_3;
  data_t     b_3;
  ctrl_t     ctrl_3;
  data_t     ya;
  data_t     yb;
  flags_t    fa;
  flags_t    fb;
  logic      wec;
  reg_addr_t addrc;
  data_t     dc;
  logic      set_pc;                          // taken jump, also the flush
  data_t     pc_target;

  sxp_fetch fetch_i (
    .clk(clk), .reset_b(reset_b), .halt(halt), .stall(stall_fe),
    .set_pc(set_pc), .pc_target(pc_target), .mem_inst(mem_inst),
    .mem_pc(mem_pc), .inst(inst_1), .inst_vld(inst_vld_1), .pcn(pcn_1));

  sxp_decode decode_i (
    .clk(clk), .reset_b(reset_b), .halt(halt), .stall(stall_fe), .flush(set_pc),
    .inst(inst_1), .inst_vld(inst_vld_1), .pcn(pcn_1), .qra(qra), .qrb(qrb),
    .addra(addra), .addrb(addrb), .a_en(a_en), .b_en(b_en), .dest_en(dest_en),
    .a_3(a_3), .b_3(b_3), .ctrl_3(ctrl_3));

  sxp_regf regf_i (
    .clk(clk), .reset_b(reset_b), .halt(halt),
    .addra(addra), .addrb(addrb), .a_en(a_en), .b_en(b_en),
    .wec(wec), .addrc(addrc), .dc(dc), .qra(qra), .qrb(qrb));

  sxp_scoreboard scoreboard_i (
    .clk(clk), .reset_b(reset_b), .halt(halt), .flush(set_pc),
    .dest_en(dest_en), .dest_addr(inst_1[`SXP_F_DADDR]),
    .addra(addra), .addrb(addrb), .a_en(a_en), .b_en(b_en),
    .wec(wec), .addrc(addrc), .stall(stall_fe));

  sxp_alu alu_i (
    .op(ctrl_3.alu_op), .a(a_3), .b(b_3),
    .ya(ya), .yb(yb), .fa(fa), .fb(fb));

  sxp_writeback writeback_i (
    .clk(clk), .reset_b(reset_b), .halt(halt), .flush(set_pc),
    .ctrl_3(ctrl_3), .ya(ya), .yb(yb), .fa(fa), .fb(fb),
    .wec(wec), .addrc(addrc), .dc(dc), .set_pc(set_pc),
    .pc_target(pc_target), .spw(spw));

endmodule

`default_nettype wire

// ==== tb_sxp.sv ====
// SXP core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sxp;
  import sxp_pkg::*;

  localparam int    prog_n         = 32;           // program words at the file start
  localparam int    pat_n          = 96;
  localparam int    reset_cycles   = 16;
  localparam int    timeout_cycles = 2000;
  localparam int    drain_cycles   = 20;           // window for late or repeated stores
  localparam inst_t nop_word       = 32'hc000_0000; // destination 11

  logic        clk;
  logic        reset_b;
  logic        halt;
  inst_t       mem_inst;
  data_t       mem_pc;
  store_t      spw;

  logic [31:0] pat [0:pat_n-1];                 // program, count, address data pairs
  data_t       last_pc;                         // address seen in the previous cycle
  integer      seed;
  int          cycle;
  int          halt_left;                       // remaining cycles of a halt burst
  int          exp_count;
  int          got;                             // stores observed so far
  int          errors;

  sxp_core sxp_core_i (
    .clk(clk), .reset_b(reset_b), .halt(halt), .mem_inst(mem_inst),
    .mem_pc(mem_pc), .spw(spw));

  always #5 clk = ~clk;

  // program word for an address, nop past the program
  function automatic inst_t prog_word(input data_t addr);
    if (addr < 32'(prog_n))
      return pat[addr[4:0]];
    return nop_word;
  endfunction

  // which program section a store belongs to
  function automatic string store_test(input int idx);
    if (idx < 8)
      return "imm_alu";
    if (idx < 9)
      return "dependent";
    if (idx < 15)
      return "flags";
    return "jumps";
  endfunction

  task automatic check_store(input int idx, input data_t addr, input data_t data);
    data_t exp_addr;
    data_t exp_data;
    exp_addr = pat[prog_n + 1 + 2*idx];
    exp_data = pat[prog_n + 2 + 2*idx];
    assert (addr == exp_addr && data == exp_data)
    else
    begin
      errors = errors + 1;
      $display("MISMATCH %s store %0d: expected %h @ %h, actual %h @ %h",
               store_test(idx), idx, exp_data, exp_addr, data, addr);
    end
  endtask

  // memory answers one cycle late, halt comes in short random bursts
  always @(posedge clk)
  begin
    #1;
    cycle = cycle + 1;
    if (cycle == reset_cycles)
      reset_b = 1'b1;
    mem_inst = prog_word(last_pc);
    last_pc  = mem_pc;
    if (!reset_b)
      halt = 1'b0;
    else if (halt_left > 0)
    begin
      halt      = 1'b1;
      halt_left = halt_left - 1;
    end
    else if (($random(seed) & 7) == 0)
    begin
      halt      = 1'b1;
      halt_left = $unsigned($random(seed)) % 3; // burst of 1 to 3
    end
    else
      halt = 1'b0;
  end

  // outputs are settled at the falling edge
  always @(negedge clk)
  begin
    if (!reset_b)
    begin
      assert (!spw.we && mem_pc == '0)
      else
      begin
        errors = errors + 1;
        $display("store strobe or fetch address active during reset");
      end
    end
    else if (spw.we)
    begin
      assert (got < exp_count)
      else
      begin
        errors = errors + 1;
        $display("unexpected extra store of %h to %h", spw.data, spw.addr);
      end
      if (got < exp_count)
        check_store(got, spw.addr, spw.data);
      got = got + 1;
    end
  end

  initial
  begin
    int wait_n;
    clk       = 1'b0;
    reset_b   = 1'b0;
    halt      = 1'b0;
    mem_inst  = nop_word;
    last_pc   = '0;
    seed      = 32'hcc0fc903;
    cycle     = 0;
    halt_left = 0;
    got       = 0;
    errors    = 0;
    $readmemh("sxp_patterns.mem", pat);
    exp_count = pat[prog_n];                    // store count follows the program
    wait_n    = 0;
    while (got < exp_count && wait_n < timeout_cycles)
    begin
      @(posedge clk);
      wait_n = wait_n + 1;
    end
    assert (got >= exp_count)
    else
    begin
      errors = errors + 1;
      $display("timeout after %0d cycles with %0d of %0d stores seen",
               timeout_cycles, got, exp_count);
    end
    wait_n = 0;
    while (wait_n < drain_cycles)                 // nothing more may be stored
    begin
      @(posedge clk);
      wait_n = wait_n + 1;
    end
    $display("stores seen %0d of %0d, errors %0d", got, exp_count, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sxp_patterns.mem ====
// words 0 to 31 are the program, four per line; word 32 is the store count
// then one expected store per line: address, data
0F010005 0F020003 88010100 89010101   // r1 = 5, r2 = 3, store add, store sub
8A010107 8B020108 8C020109 8D020104   // store and, or, xor, shl
8E010102 8F010103 00031200 00033100   // store shr, passb, r3 = r1 + r2, r3 += r1
8D030120 0F040150 0F050001 0D05001F   // store r3, r4 = 0x150, r5 = 1, r5 <<= 31
89520140 89720141 89440150 89650160   // flags n, c, z, v from subtractions
89750161 80705500 5F000019 8D0101E0   // c clear, add carry, jump to 25, skipped
8D0201E0 0F060003 50000601 8D0101F0   // skipped, r6 = 3, taken jump to 30, skipped
8D0201F0 8D0301F0 50000603 8D0601C0   // skipped, skipped, not taken, store r6
00000010
00000100 00000105
00000101 FFFFFF04
00000107 00000005
00000108 0000010B
00000109 0000010A
00000104 00000030
00000102 00000001
00000103 00000103
00000120 0000000D
00000140 00000001
00000141 00000001
00000150 00000001
00000160 00000001
00000161 00000000
80000000 00000001
000001C0 00000003

// ==== vlog.f ====
+incdir+.
sxp_pkg.sv
sxp_fetch.sv
sxp_regf.sv
sxp_scoreboard.sv
sxp_decode.sv
sxp_alu.sv
sxp_writeback.sv
sxp_core.sv
tb_sxp.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = tb_sxp
FILELIST  = vlog.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
